/* verilog/rv_decode_config.svh */
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// data path width
`define XLEN 32

// instruction queue entries
// fetch side starts with this many credits
`define IQ_DEPTH 4

// execute stage slots
`define EX_CREDITS 2

`endif

/* verilog/rv_decode_pkg.sv */
`include "rv_decode_config.svh"

package rv_decode_pkg;

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [4:0] shamt_t;

	// rv32i base opcodes
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011
	} opcode_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_CREDIT
	} issue_state_t;

	typedef struct packed {
		xlen_t pc;
		xlen_t instr;
	} fetch_pkt_t;

	typedef struct packed {
		reg_addr_t rd;
		funct3_t   funct3;
		reg_addr_t adr1;
		reg_addr_t adr2;
		shamt_t    shamt;
		funct7_t   funct7;
		xlen_t     imm;
	} pre_dec_t;

	typedef struct packed {
		xlen_t    pc;
		opcode_t  opcode;
		pre_dec_t fields;
		xlen_t    rs1_data;
		xlen_t    rs2_data;
	} dec_instr_t;

endpackage

/* verilog/pre_decoder.sv */
`include "rv_decode_config.svh"

module pre_decoder (
	input  rv_decode_pkg::xlen_t    instr,
	input  rv_decode_pkg::opcode_t  opcode,
	output rv_decode_pkg::pre_dec_t fields
);
	import rv_decode_pkg::*;

	reg_addr_t rd_addr;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	funct3_t funct3_dat;
	funct7_t funct7_dat;
	shamt_t shamt_dat;

	xlen_t i_imm;
	xlen_t s_imm;
	xlen_t b_imm;
	xlen_t u_imm;
	xlen_t j_imm;

	assign rd_addr = instr[11:7];
	assign rs1_addr = instr[19:15];
	assign rs2_addr = instr[24:20];
	assign funct3_dat = instr[14:12];
	assign funct7_dat = instr[31:25];
	assign shamt_dat = instr[24:20];

	// immediates, all sign extended except U
	assign i_imm = {{20{instr[31]}}, instr[31:20]};
	assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign u_imm = {instr[31:12], 12'b0};
	assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		fields = '0;
		case (opcode)
			LUI, AUIPC: begin
				fields.rd = rd_addr;
				fields.imm = u_imm;
			end
			JAL: begin
				fields.rd = rd_addr;
				fields.imm = j_imm;
			end
			JALR, LOAD: begin
				fields.rd = rd_addr;
				fields.funct3 = funct3_dat;
				fields.adr1 = rs1_addr;
				fields.imm = i_imm;
			end
			BRANCH, STORE: begin
				fields.funct3 = funct3_dat;
				fields.adr1 = rs1_addr;
				fields.adr2 = rs2_addr;
				fields.imm = (opcode == BRANCH) ? b_imm : s_imm;
			end
			OP_IMM: begin
				fields.rd = rd_addr;
				fields.funct3 = funct3_dat;
				fields.adr1 = rs1_addr;
				// slli, srli and srai carry shamt instead of an immediate
				if (funct3_dat == 3'b001 || funct3_dat == 3'b101) begin
					fields.shamt = shamt_dat;
					fields.funct7 = funct7_dat;
				end else begin
					fields.imm = i_imm;
				end
			end
			default: begin
				// OP, and anything unrecognised
				fields.rd = rd_addr;
				fields.funct3 = funct3_dat;
				fields.adr1 = rs1_addr;
				fields.adr2 = rs2_addr;
				fields.funct7 = funct7_dat;
			end
		endcase
	end

endmodule

/* verilog/instr_queue.sv */
`include "rv_decode_config.svh"

module instr_queue (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      push,
	input  rv_decode_pkg::fetch_pkt_t push_pkt,
	input  logic                      pop,
	output rv_decode_pkg::fetch_pkt_t head,
	output logic                      empty,
	output logic                      fetch_credit
);
	import rv_decode_pkg::*;

	localparam int PTR_W = $clog2(`IQ_DEPTH);
	localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

	fetch_pkt_t mem [`IQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;

	assign empty = (count == 0);
	assign full = (count == `IQ_DEPTH);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_pkt;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			fetch_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back to fetch per freed entry
			fetch_credit <= pop;
		end
	end

	// fetch sent without holding a credit
	assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("instr_queue: push while full");

	assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("instr_queue: pop while empty");

endmodule

/* verilog/credit_counter.sv */
`include "rv_decode_config.svh"

module credit_counter (
	input  logic clk,
	input  logic reset,
	input  logic spend,
	input  logic refund,
	output logic avail
);

	localparam int CNT_W = $clog2(`EX_CREDITS + 1);

	logic [CNT_W-1:0] count;

	assign avail = (count != 0);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= CNT_W'(`EX_CREDITS);
		end else begin
			// spend and refund together leave the count alone
			case ({spend, refund})
				2'b10: count <= count - 1'b1;
				2'b01: count <= count + 1'b1;
				default: count <= count;
			endcase
		end
	end

	// execute returned more credits than it has slots
	assert property (@(posedge clk) disable iff (reset) count <= `EX_CREDITS)
		else $error("credit_counter: count above EX_CREDITS");

endmodule

/* verilog/reg_file.sv */
module reg_file (
	input  logic                     clk,
	input  logic                     reset,
	input  rv_decode_pkg::reg_addr_t rs1,
	input  rv_decode_pkg::reg_addr_t rs2,
	output rv_decode_pkg::xlen_t     rs1_data,
	output rv_decode_pkg::xlen_t     rs2_data,
	input  logic                     wb_en,
	input  rv_decode_pkg::reg_addr_t wb_addr,
	input  rv_decode_pkg::xlen_t     wb_data
);
	import rv_decode_pkg::*;

	// x0 has no storage
	xlen_t regs [1:31];
	logic wb_live;

	assign wb_live = wb_en && (wb_addr != 0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_live) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// write-first bypass on both ports
	always_comb begin
		if (rs1 == 0)
			rs1_data = '0;
		else if (wb_live && wb_addr == rs1)
			rs1_data = wb_data;
		else
			rs1_data = regs[rs1];

		if (rs2 == 0)
			rs2_data = '0;
		else if (wb_live && wb_addr == rs2)
			rs2_data = wb_data;
		else
			rs2_data = regs[rs2];
	end

endmodule

/* verilog/issue_ctrl.sv */
module issue_ctrl (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      head_ready,
	input  logic                      credit_avail,
	input  rv_decode_pkg::dec_instr_t dec_in,
	output logic                      pop,
	output logic                      spend,
	output logic                      ex_valid,
	output rv_decode_pkg::dec_instr_t ex_instr
);
	import rv_decode_pkg::*;

	issue_state_t state;
	issue_state_t next_state;
	logic issue;

	// head goes out whenever a slot is free downstream
	assign issue = head_ready && credit_avail;
	assign pop = issue;
	assign spend = issue;

	always_comb begin
		if (issue)
			next_state = ISSUE;
		else if (head_ready)
			next_state = WAIT_CREDIT;
		else
			next_state = IDLE;
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	// record captured at the issue edge, regs included
	always_ff @(posedge clk) begin
		if (issue)
			ex_instr <= dec_in;
	end

	// ISSUE lasts one cycle per record sent
	assign ex_valid = (state == ISSUE);

	// a record leaving for execute is fully known
	assert property (@(posedge clk) disable iff (reset) issue |-> !$isunknown(dec_in))
		else $error("issue_ctrl: issuing a record with unknown bits");

endmodule

/* verilog/decode_stage.sv */
module decode_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      fetch_valid,
	input  rv_decode_pkg::fetch_pkt_t fetch_pkt,
	output logic                      fetch_credit,
	output logic                      ex_valid,
	output rv_decode_pkg::dec_instr_t ex_instr,
	input  logic                      ex_credit,
	input  logic                      wb_en,
	input  rv_decode_pkg::reg_addr_t  wb_addr,
	input  rv_decode_pkg::xlen_t      wb_data
);
	import rv_decode_pkg::*;

	fetch_pkt_t head;
	logic empty;
	logic head_ready;
	logic pop;
	logic spend;
	logic credit_avail;
	opcode_t opcode;
	pre_dec_t fields;
	xlen_t rs1_data;
	xlen_t rs2_data;
	dec_instr_t dec_in;

	assign head_ready = !empty;
	assign opcode = opcode_t'(head.instr[6:0]);

	instr_queue u_queue (
		.clk(clk),
		.reset(reset),
		.push(fetch_valid),
		.push_pkt(fetch_pkt),
		.pop(pop),
		.head(head),
		.empty(empty),
		.fetch_credit(fetch_credit)
	);

	pre_decoder u_pre_dec (
		.instr(head.instr),
		.opcode(opcode),
		.fields(fields)
	);

	reg_file u_regs (
		.clk(clk),
		.reset(reset),
		.rs1(fields.adr1),
		.rs2(fields.adr2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	credit_counter u_credits (
		.clk(clk),
		.reset(reset),
		.spend(spend),
		.refund(ex_credit),
		.avail(credit_avail)
	);

	assign dec_in = '{
		pc: head.pc,
		opcode: opcode,
		fields: fields,
		rs1_data: rs1_data,
		rs2_data: rs2_data
	};

	issue_ctrl u_issue (
		.clk(clk),
		.reset(reset),
		.head_ready(head_ready),
		.credit_avail(credit_avail),
		.dec_in(dec_in),
		.pop(pop),
		.spend(spend),
		.ex_valid(ex_valid),
		.ex_instr(ex_instr)
	);

endmodule

/* test/decode_stage_tb.sv */
`include "rv_decode_config.svh"

module decode_stage_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_decode_pkg::*;

	localparam int NROWS = 22;
	localparam int CLK_NS = 40;

	// one table row: instruction word, expected opcode, test number
	typedef struct packed {
		xlen_t      word;
		opcode_t    op;
		logic [2:0] test;
	} row_t;

	logic clk;
	logic reset;
	logic fetch_valid;
	fetch_pkt_t fetch_pkt;
	logic fetch_credit;
	logic ex_valid;
	dec_instr_t ex_instr;
	logic ex_credit;
	logic wb_en;
	reg_addr_t wb_addr;
	xlen_t wb_data;

	row_t rows [NROWS];
	xlen_t reg_model [32];
	dec_instr_t exp_q [$];
	int accept_q [$];
	int due_q [$];
	logic [31:0] rng = 32'd76026;
	xlen_t next_pc = 32'h0000_1000;
	int cycle = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int fetch_credits = `IQ_DEPTH;
	int ex_free = `EX_CREDITS;
	int issued = 0;
	int credit_pulses = 0;
	int last_due = 0;
	bit hold = 1'b0;
	bit check_timing = 1'b0;

	decode_stage UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(NROWS * 20 * CLK_NS);
		$display("timeout: DUT stopped making progress at cycle %0d", cycle);
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// reference decode, keep bits are {rd, funct3, adr1, adr2, shamt, funct7}
	function automatic pre_dec_t ref_decode(xlen_t w);
		pre_dec_t f;
		logic [5:0] keep;
		xlen_t sx;
		sx = {32{w[31]}};
		f.imm = '0;
		case (w[6:0])
			LUI, AUIPC: begin
				keep = 6'b100000;
				f.imm = {w[31:12], 12'h000};
			end
			JAL: begin
				keep = 6'b100000;
				f.imm = {sx[11:0], w[19:12], w[20], w[30:21], 1'b0};
			end
			JALR, LOAD: begin
				keep = 6'b111000;
				f.imm = {sx[19:0], w[31:20]};
			end
			STORE: begin
				keep = 6'b011100;
				f.imm = {sx[19:0], w[31:25], w[11:7]};
			end
			BRANCH: begin
				keep = 6'b011100;
				f.imm = {sx[19:0], w[7], w[30:25], w[11:8], 1'b0};
			end
			OP_IMM: begin
				keep = (w[13:12] == 2'b01) ? 6'b111011 : 6'b111000;
				if (w[13:12] != 2'b01)
					f.imm = {sx[19:0], w[31:20]};
			end
			default: keep = 6'b111101;
		endcase
		f.rd = keep[5] ? w[11:7] : '0;
		f.funct3 = keep[4] ? w[14:12] : '0;
		f.adr1 = keep[3] ? w[19:15] : '0;
		f.adr2 = keep[2] ? w[24:20] : '0;
		f.shamt = keep[1] ? w[24:20] : '0;
		f.funct7 = keep[0] ? w[31:25] : '0;
		return f;
	endfunction

	function automatic dec_instr_t build_expected(row_t r, xlen_t pc);
		dec_instr_t e;
		e.pc = pc;
		e.opcode = r.op;
		e.fields = ref_decode(r.word);
		e.rs1_data = reg_model[e.fields.adr1];
		e.rs2_data = reg_model[e.fields.adr2];
		return e;
	endfunction

	task automatic check_record(dec_instr_t got, dec_instr_t exp);
		if ({got.pc, got.opcode, got.fields} !== {exp.pc, exp.opcode, exp.fields}) begin
			$display("Mismatch at %0t: ex_instr got %h expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(string name, xlen_t got, xlen_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// outputs are registered, so the values just before the edge are stable
	always @(posedge clk) begin : monitor
		dec_instr_t exp;
		int acc;
		int delay;
		cycle++;
		if (!reset && fetch_credit) begin
			credit_pulses++;
			fetch_credits++;
			if (fetch_credits > `IQ_DEPTH) begin
				$display("fetch credit returned for an entry that was never sent");
				errors++;
			end
		end
		if (!reset && ex_valid) begin
			issued++;
			if (ex_free == 0) begin
				$display("record issued at %0t with no execute credit left", $time);
				errors++;
			end
			ex_free--;
			delay = cycle + 1 + int'(xorshift() % 32'd4);
			last_due = (delay > last_due) ? delay : last_due + 1;
			due_q.push_back(last_due);
			if (exp_q.size() == 0) begin
				$display("record issued at %0t that was never sent", $time);
				errors++;
			end else begin
				exp = exp_q.pop_front();
				acc = accept_q.pop_front();
				check_record(ex_instr, exp);
				check_word("ex_instr.rs1_data", ex_instr.rs1_data, exp.rs1_data);
				check_word("ex_instr.rs2_data", ex_instr.rs2_data, exp.rs2_data);
				// ex_valid seen two edges after the accepting edge
				if (check_timing && cycle != acc + 2) begin
					$display("record at pc %h issued %0d edges after acceptance, not 2",
						exp.pc, cycle - acc);
					errors++;
				end
			end
		end
	end

	// execute side, one credit per cycle once its delay has run out
	always @(negedge clk) begin
		ex_credit = 1'b0;
		if (!hold && due_q.size() > 0 && due_q[0] <= cycle) begin
			void'(due_q.pop_front());
			ex_credit = 1'b1;
			ex_free++;
		end
	end

	task automatic send_row(row_t r);
		while (fetch_credits == 0)
			@(negedge clk);
		fetch_valid = 1'b1;
		fetch_pkt.pc = next_pc;
		fetch_pkt.instr = r.word;
		fetch_credits--;
		exp_q.push_back(build_expected(r, next_pc));
		accept_q.push_back(cycle + 1);
		next_pc += 4;
		@(negedge clk);
		fetch_valid = 1'b0;
	endtask

	// bypass patches the newest record, which issues on this same edge
	task automatic write_reg(reg_addr_t a, xlen_t d, bit bypass);
		dec_instr_t last;
		wb_en = 1'b1;
		wb_addr = a;
		wb_data = d;
		if (a != 0)
			reg_model[a] = d;
		if (bypass) begin
			last = exp_q.pop_back();
			last.rs1_data = reg_model[last.fields.adr1];
			last.rs2_data = reg_model[last.fields.adr2];
			exp_q.push_back(last);
		end
		@(negedge clk);
		wb_en = 1'b0;
	endtask

	task automatic wait_ready(bit all_back);
		while (exp_q.size() != 0 || ex_free == 0 || (all_back && ex_free != `EX_CREDITS))
			@(negedge clk);
	endtask

	task automatic apply_rows(int tag, bit one_at_a_time);
		for (int i = 0; i < NROWS; i++) begin
			if (tag == 0 || rows[i].test == tag) begin
				if (one_at_a_time)
					wait_ready(1'b0);
				send_row(rows[i]);
			end
		end
	endtask

	task automatic end_test(int num, string name, int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - start_errors);
		end
	endtask

	initial begin : main
		int start;
		int issued_before;
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_pkt = '0;
		ex_credit = 1'b0;
		wb_en = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		for (int i = 0; i < 32; i++)
			reg_model[i] = '0;
		rows[0] = {32'h123450B7, LUI, 3'd1};
		rows[1] = {32'h00001297, AUIPC, 3'd1};
		rows[2] = {32'h008000EF, JAL, 3'd1};
		rows[3] = {32'h00C50567, JALR, 3'd1};
		rows[4] = {32'h00412083, LOAD, 3'd1};
		rows[5] = {32'h00312423, STORE, 3'd1};
		rows[6] = {32'h00208463, BRANCH, 3'd1};
		rows[7] = {32'h06410093, OP_IMM, 3'd1};
		rows[8] = {32'h00311113, OP_IMM, 3'd1};
		rows[9] = {32'h003100B3, OP, 3'd1};
		rows[10] = {32'h00000073, opcode_t'(7'b1110011), 3'd1};
		rows[11] = {32'h7FF18193, OP_IMM, 3'd2};
		rows[12] = {32'hFFF18193, OP_IMM, 3'd2};
		rows[13] = {32'hFFC12083, LOAD, 3'd2};
		rows[14] = {32'hFE112E23, STORE, 3'd2};
		rows[15] = {32'hFE208EE3, BRANCH, 3'd2};
		rows[16] = {32'hFF5FF0EF, JAL, 3'd2};
		rows[17] = {32'hABCDE0B7, LUI, 3'd2};
		rows[18] = {32'h4051D193, OP_IMM, 3'd2};
		rows[19] = {32'h40208133, OP, 3'd3};
		rows[20] = {32'h000002B3, OP, 3'd3};
		rows[21] = {32'h01FF8FB3, OP, 3'd3};
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// fill x1..x31, then try x0
		for (int i = 1; i < 32; i++)
			write_reg(reg_addr_t'(i), xorshift(), 1'b0);
		write_reg(5'd0, xorshift(), 1'b0);

		start = errors;
		apply_rows(1, 1'b0);
		wait_ready(1'b1);
		end_test(1, "field selection", start);

		start = errors;
		apply_rows(2, 1'b0);
		wait_ready(1'b1);
		end_test(2, "immediates", start);

		start = errors;
		for (int i = 0; i < NROWS; i++) begin
			if (rows[i].test == 3) begin
				wait_ready(1'b0);
				send_row(rows[i]);
				write_reg(rows[i].word[24:20], xorshift(), 1'b1);
			end
		end
		wait_ready(1'b1);
		end_test(3, "register data", start);

		start = errors;
		check_timing = 1'b1;
		apply_rows(1, 1'b1);
		wait_ready(1'b1);
		check_timing = 1'b0;
		end_test(4, "ordering and latency", start);

		start = errors;
		hold = 1'b1;
		issued_before = issued;
		fork
			apply_rows(0, 1'b0);
			begin
				repeat (12) @(negedge clk);
				// queue is full by now, so every execute slot got used
				if (issued - issued_before != `EX_CREDITS) begin
					$display("%0d records issued with execute credits withheld, expected %0d",
						issued - issued_before, `EX_CREDITS);
					errors++;
				end
				hold = 1'b0;
			end
		join
		wait_ready(1'b1);
		end_test(5, "back-pressure", start);

		start = errors;
		if (credit_pulses != issued) begin
			$display("%0d fetch credit pulses for %0d issued records", credit_pulses, issued);
			errors++;
		end
		if (fetch_credits != `IQ_DEPTH) begin
			$display("fetch side ended with %0d credits instead of %0d", fetch_credits,
				`IQ_DEPTH);
			errors++;
		end
		end_test(6, "fetch credits", start);

		$display("%0d tests run, %0d failed, %0d records issued, %0d errors total",
			tests_run, tests_failed, issued, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* sim.f */
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/pre_decoder.sv
verilog/instr_queue.sv
verilog/credit_counter.sv
verilog/reg_file.sv
verilog/issue_ctrl.sv
verilog/decode_stage.sv
test/decode_stage_tb.sv

/* Bender.yml */
package:
  name: rv_decode_stage

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/rv_decode_pkg.sv
      - verilog/pre_decoder.sv
      - verilog/instr_queue.sv
      - verilog/credit_counter.sv
      - verilog/reg_file.sv
      - verilog/issue_ctrl.sv
      - verilog/decode_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/decode_stage_tb.sv
